// File: source/loop_pkg.sv
`default_nettype none

package loop_pkg;

    // entry and datapath widths
    localparam int entry_w = 48;
    localparam int itr_w   = 32;  // loop iterators and compare values
    localparam int acc_w   = 64;
    localparam int data_w  = 32;  // axi-lite data and stream words
    localparam int reg_aw  = 8;   // byte address bits of the register map

    // field positions inside one table entry
    localparam int valid_bit = 47;
    localparam int level_lo  = 45;  // 2 bits
    localparam int sc_lo     = 40;
    localparam int num_sc_lo = 35;
    localparam int sc_w      = 5;   // width of sc and num_sc
    localparam int type_lo   = 33;  // 2 bits
    // triggered_on sits in the low itr_w bits

    typedef enum logic [1:0] {
        init           = 2'b00,  // loop header, loads the bound
        body_check_end = 2'b01   // body plus closing brace
    } entry_type_e;

    typedef enum logic [1:0] {
        lvl_k = 2'b00,  // innermost
        lvl_j = 2'b01,
        lvl_i = 2'b10   // outermost
    } level_e;

    // stream-in handshake states
    typedef enum logic [1:0] {
        waiting         = 2'b00,
        inbound_started = 2'b01,
        ready_hold      = 2'b10,
        ready           = 2'b11
    } seq_state_e;

    typedef enum logic [reg_aw-1:0] {
        reg_ctrl     = 8'h00,  // write starts a run
        reg_status   = 8'h04,  // bit 0 done
        reg_acc_lo   = 8'h08,
        reg_acc_hi   = 8'h0c,
        reg_entry_lo = 8'h10,
        reg_entry_hi = 8'h14   // commits the staged entry
    } reg_addr_e;

endpackage

`default_nettype wire

// File: source/loop_table_mem.sv
`timescale 1ns/100ps
`default_nettype none

module loop_table_mem #(
    parameter  int table_depth = 32,
    localparam int ptr_w       = $clog2(table_depth)
) (
    input  wire                         clk,
    input  wire                         we_i,
    input  wire [ptr_w-1:0]             addr_i,
    input  wire [loop_pkg::entry_w-1:0] wdata_i,
    output logic [loop_pkg::entry_w-1:0] rdata_o
);
    import loop_pkg::*;

    logic [entry_w-1:0] mem_q [table_depth];  // state table

    // single port, read data one cycle after the address
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];  // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: source/table_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module table_arbiter #(
    parameter  int table_depth = 32,
    localparam int ptr_w       = $clog2(table_depth)
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          seq_req_i,   // sequencer only reads
    input  wire [ptr_w-1:0]              seq_addr_i,
    input  wire                          axi_req_i,
    input  wire [ptr_w-1:0]              axi_addr_i,
    input  wire                          axi_we_i,
    input  wire [loop_pkg::entry_w-1:0]  axi_wdata_i,
    output logic                         seq_gnt_o,
    output logic                         axi_gnt_o,
    output logic                         mem_we_o,
    output logic [ptr_w-1:0]             mem_addr_o,
    output logic [loop_pkg::entry_w-1:0] mem_wdata_o,
    output logic                         seq_rvalid_o
);

    // fixed priority, sequencer first
    assign seq_gnt_o = seq_req_i;
    assign axi_gnt_o = axi_req_i && !seq_req_i;  // axi waits out sequencer fetches

    assign mem_we_o    = axi_gnt_o && axi_we_i;
    assign mem_addr_o  = seq_gnt_o ? seq_addr_i : axi_addr_i;
    assign mem_wdata_o = axi_wdata_i;

    // read data returning next cycle belongs to the sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rvalid_o <= 1'b0;
        end else begin
            seq_rvalid_o <= seq_gnt_o;
        end
    end

endmodule

`default_nettype wire

// File: source/axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

module axil_regs #(
    parameter  int table_depth = 32,
    localparam int ptr_w       = $clog2(table_depth)
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [loop_pkg::reg_aw-1:0]   awaddr_i,
    input  wire                          awvalid_i,
    output logic                         awready_o,
    input  wire [loop_pkg::data_w-1:0]   wdata_i,
    input  wire [3:0]                    wstrb_i,
    input  wire                          wvalid_i,
    output logic                         wready_o,
    output logic [1:0]                   bresp_o,
    output logic                         bvalid_o,
    input  wire                          bready_i,
    input  wire [loop_pkg::reg_aw-1:0]   araddr_i,
    input  wire                          arvalid_i,
    output logic                         arready_o,
    output logic [loop_pkg::data_w-1:0]  rdata_o,
    output logic [1:0]                   rresp_o,
    output logic                         rvalid_o,
    input  wire                          rready_i,
    output logic                         table_req_o,
    output logic [ptr_w-1:0]             table_addr_o,
    output logic [loop_pkg::entry_w-1:0] table_wdata_o,
    input  wire                          table_gnt_i,
    output logic                         load_done_o,  // one cycle per ctrl write
    input  wire                          done_i,
    input  wire [loop_pkg::acc_w-1:0]    acc_i
);
    import loop_pkg::*;

    logic              wr_go;        // aw and w taken together
    logic              rd_go;
    reg_addr_e         wr_reg;
    logic [data_w-1:0] entry_lo_q;   // staged entry halves
    logic [data_w-1:0] entry_hi_q;
    logic [ptr_w-1:0]  table_idx_q;  // next row to commit
    logic              done_q;       // sticky status

    // byte-lane merge of a new word into a staged one
    function automatic logic [data_w-1:0] merge(input logic [data_w-1:0] old_v,
                                                input logic [data_w-1:0] new_v,
                                                input logic [3:0]        strb);
        logic [data_w-1:0] res;
        res = old_v;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return res;
    endfunction

    // one write in flight, until its response is taken
    assign wr_go     = awvalid_i && wvalid_i && !table_req_o && !bvalid_o;
    assign awready_o = wr_go;
    assign wready_o  = wr_go;
    assign wr_reg    = reg_addr_e'(awaddr_i);
    assign bresp_o   = 2'b00;  // always okay
    assign rresp_o   = 2'b00;

    assign table_addr_o  = table_idx_q;
    assign table_wdata_o = {entry_hi_q[entry_w-data_w-1:0], entry_lo_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_o    <= 1'b0;
            table_req_o <= 1'b0;
            table_idx_q <= '0;
            load_done_o <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            load_done_o <= 1'b0;
            if (done_i) begin
                done_q <= 1'b1;
            end
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
            // entry commit finishes on the grant
            if (table_req_o && table_gnt_i) begin
                table_req_o <= 1'b0;
                table_idx_q <= table_idx_q + 1'b1;
                bvalid_o    <= 1'b1;
            end
            if (wr_go) begin
                case (wr_reg)
                    reg_ctrl: begin
                        load_done_o <= 1'b1;
                        table_idx_q <= '0;    // next load starts at row 0
                        done_q      <= 1'b0;  // new run
                        bvalid_o    <= 1'b1;
                    end
                    reg_entry_hi: table_req_o <= 1'b1;  // bvalid after grant
                    default:      bvalid_o    <= 1'b1;
                endcase
            end
        end
    end

    // entry staging
    always_ff @(posedge clk) begin
        if (wr_go && wr_reg == reg_entry_lo) begin
            entry_lo_q <= merge(entry_lo_q, wdata_i, wstrb_i);
        end
        if (wr_go && wr_reg == reg_entry_hi) begin
            entry_hi_q <= merge(entry_hi_q, wdata_i, wstrb_i);
        end
    end

    // read channel, rdata held while rvalid waits on rready
    assign rd_go     = arvalid_i && !rvalid_o;
    assign arready_o = rd_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_o <= 1'b0;
        end else if (rd_go) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            case (reg_addr_e'(araddr_i))
                reg_status: rdata_o <= {{(data_w-1){1'b0}}, done_q};
                reg_acc_lo: rdata_o <= acc_i[data_w-1:0];
                reg_acc_hi: rdata_o <= acc_i[acc_w-1:data_w];
                default:    rdata_o <= '0;  // write-only and unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/loop_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module loop_sequencer #(
    parameter  int table_depth = 32,
    localparam int ptr_w       = $clog2(table_depth)
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         load_done_i,
    input  wire                         start_stream_i,
    output logic                        ready_stream_o,
    output logic                        done_o,
    output logic                        mem_req_o,
    output logic [ptr_w-1:0]            mem_addr_o,
    input  wire                         mem_rvalid_i,
    input  wire [loop_pkg::entry_w-1:0] entry_i,
    output logic [loop_pkg::itr_w-1:0]  itr_i_o,
    output logic [loop_pkg::itr_w-1:0]  itr_j_o,
    output logic [loop_pkg::itr_w-1:0]  itr_k_o
);
    import loop_pkg::*;

    seq_state_e       state_q;
    seq_state_e       state_d;
    logic             phase_q;     // high in the data cycle of a fetch
    logic [ptr_w-1:0] ptr_q;       // smart pointer into the table
    logic [itr_w-1:0] itr_i_q, itr_j_q, itr_k_q;
    logic [itr_w-1:0] cmp_i_q, cmp_j_q, cmp_k_q;  // loop bounds
    logic [ptr_w-1:0] label_j_q;   // first row of the j body
    logic [ptr_w-1:0] label_k_q;   // first row of the i body, reached from i check

    logic             e_valid;
    level_e           e_level;
    entry_type_e      e_type;
    logic [sc_w-1:0]  e_sc;
    logic [sc_w-1:0]  e_num_sc;
    logic [itr_w-1:0] e_trig;
    logic             fire;        // entry on entry_i is live
    logic             last_sc;
    logic             done;

    // entry fields
    assign e_valid  = entry_i[valid_bit];
    assign e_level  = level_e'(entry_i[level_lo +: 2]);
    assign e_sc     = entry_i[sc_lo +: sc_w];
    assign e_num_sc = entry_i[num_sc_lo +: sc_w];
    assign e_type   = entry_type_e'(entry_i[type_lo +: 2]);
    assign e_trig   = entry_i[itr_w-1:0];

    assign fire    = (state_q == ready) && phase_q && mem_rvalid_i;
    assign last_sc = (e_sc == e_num_sc - 1'b1);
    assign done    = fire && !e_valid && (ptr_q != '0);  // row 0 invalid is not an end

    // handshake FSM
    always_comb begin
        case (state_q)
            waiting:         state_d = load_done_i ? inbound_started : waiting;
            inbound_started: state_d = (start_stream_i && !load_done_i) ? ready_hold
                                                                        : inbound_started;
            ready_hold:      state_d = start_stream_i ? ready_hold : ready;
            ready:           state_d = done ? waiting : ready;
            default:         state_d = waiting;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= waiting;
            phase_q <= 1'b0;
        end else begin
            state_q <= state_d;
            phase_q <= (state_q == ready) ? !phase_q : 1'b0;  // address then data
        end
    end

    // table walk, one entry every two cycles
    always_ff @(posedge clk) begin
        if (rst || state_q != ready) begin
            ptr_q     <= '0;
            itr_i_q   <= '0;
            itr_j_q   <= '0;
            itr_k_q   <= '0;
            cmp_i_q   <= '0;
            cmp_j_q   <= '0;
            cmp_k_q   <= '0;
            label_j_q <= '0;
            label_k_q <= '0;
        end else if (fire) begin
            if (!e_valid) begin
                ptr_q <= '0;  // end of table
            end else if (e_type == init) begin
                ptr_q <= ptr_q + 1'b1;
                case (e_level)
                    lvl_k: cmp_k_q <= e_trig;
                    lvl_j: begin
                        cmp_j_q   <= e_trig;
                        label_j_q <= ptr_q + 1'b1;
                    end
                    lvl_i: begin
                        cmp_i_q   <= e_trig;
                        label_k_q <= ptr_q + 1'b1;
                    end
                    default: ;
                endcase
            end else if (e_type == body_check_end) begin
                if (!last_sc) begin
                    ptr_q <= ptr_q + 1'b1;  // more sub-cycles in this body
                end else begin
                    case (e_level)
                        lvl_k: begin
                            if (cmp_k_q == itr_k_q + 1'b1) begin
                                itr_k_q <= '0;
                                ptr_q   <= ptr_q + 1'b1;
                            end else begin
                                itr_k_q <= itr_k_q + 1'b1;  // same row again
                            end
                        end
                        lvl_j: begin
                            if (cmp_j_q == itr_j_q + 1'b1) begin
                                itr_j_q <= '0;
                                ptr_q   <= ptr_q + 1'b1;
                            end else begin
                                itr_j_q <= itr_j_q + 1'b1;
                                ptr_q   <= label_j_q;
                            end
                        end
                        lvl_i: begin
                            if (cmp_i_q == itr_i_q + 1'b1) begin
                                itr_i_q <= '0;
                                ptr_q   <= ptr_q + 1'b1;
                            end else begin
                                itr_i_q <= itr_i_q + 1'b1;
                                ptr_q   <= label_k_q;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    assign mem_req_o      = (state_q == ready) && !phase_q;  // address cycle
    assign mem_addr_o     = ptr_q;
    assign ready_stream_o = (state_q == ready_hold) || (state_q == ready && !done);
    assign done_o         = done;
    assign itr_i_o        = itr_i_q;
    assign itr_j_o        = itr_j_q;
    assign itr_k_o        = itr_k_q;

endmodule

`default_nettype wire

// File: source/stream_mac.sv
`timescale 1ns/100ps
`default_nettype none

module stream_mac (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        clear_i,  // start of a run
    input  wire                        valid_i,  // stream ready cycle
    input  wire [loop_pkg::data_w-1:0] data_i,
    input  wire [loop_pkg::itr_w-1:0]  itr_i_i,
    input  wire [loop_pkg::itr_w-1:0]  itr_j_i,
    input  wire [loop_pkg::itr_w-1:0]  itr_k_i,
    output logic [loop_pkg::acc_w-1:0] acc_o
);
    import loop_pkg::*;

    logic [acc_w-1:0] weight;  // i+j+k+1

    assign weight = acc_w'(itr_i_i) + acc_w'(itr_j_i) + acc_w'(itr_k_i) + 1'b1;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            acc_o <= '0;
        end else if (valid_i) begin
            acc_o <= acc_o + acc_w'(data_i) * weight;  // wraps at acc_w
        end
    end

endmodule

`default_nettype wire

// File: source/loop_top.sv
`timescale 1ns/100ps
`default_nettype none

module loop_top #(
    parameter  int table_depth = 32,
    localparam int ptr_w       = $clog2(table_depth)
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [loop_pkg::reg_aw-1:0]  awaddr_i,
    input  wire                         awvalid_i,
    output logic                        awready_o,
    input  wire [loop_pkg::data_w-1:0]  wdata_i,
    input  wire [3:0]                   wstrb_i,
    input  wire                         wvalid_i,
    output logic                        wready_o,
    output logic [1:0]                  bresp_o,
    output logic                        bvalid_o,
    input  wire                         bready_i,
    input  wire [loop_pkg::reg_aw-1:0]  araddr_i,
    input  wire                         arvalid_i,
    output logic                        arready_o,
    output logic [loop_pkg::data_w-1:0] rdata_o,
    output logic [1:0]                  rresp_o,
    output logic                        rvalid_o,
    input  wire                         rready_i,
    input  wire                         start_stream_i,
    input  wire [loop_pkg::data_w-1:0]  stream_data_i,
    output logic                        ready_stream_o,
    output logic [loop_pkg::itr_w-1:0]  itr_i_o,
    output logic [loop_pkg::itr_w-1:0]  itr_j_o,
    output logic [loop_pkg::itr_w-1:0]  itr_k_o
);
    import loop_pkg::*;

    logic               tbl_req, tbl_gnt;       // axi peer
    logic [ptr_w-1:0]   tbl_addr;
    logic [entry_w-1:0] tbl_wdata;
    logic               seq_req, seq_rvalid;    // sequencer peer
    logic [ptr_w-1:0]   seq_addr;
    logic               mem_we;
    logic [ptr_w-1:0]   mem_addr;
    logic [entry_w-1:0] mem_wdata, mem_rdata;
    logic               load_done, done;
    logic [acc_w-1:0]   acc;

    axil_regs #(.table_depth(table_depth)) u_regs (
        .clk, .rst,
        .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .table_req_o(tbl_req), .table_addr_o(tbl_addr), .table_wdata_o(tbl_wdata),
        .table_gnt_i(tbl_gnt), .load_done_o(load_done), .done_i(done), .acc_i(acc)
    );

    table_arbiter #(.table_depth(table_depth)) u_arb (
        .clk, .rst,
        .seq_req_i(seq_req), .seq_addr_i(seq_addr),
        .axi_req_i(tbl_req), .axi_addr_i(tbl_addr),
        .axi_we_i(1'b1),  // host side only writes the table
        .axi_wdata_i(tbl_wdata),
        .seq_gnt_o(), .axi_gnt_o(tbl_gnt),  // sequencer always wins
        .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
        .seq_rvalid_o(seq_rvalid)
    );

    loop_table_mem #(.table_depth(table_depth)) u_mem (
        .clk, .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

    loop_sequencer #(.table_depth(table_depth)) u_seq (
        .clk, .rst,
        .load_done_i(load_done), .start_stream_i, .ready_stream_o, .done_o(done),
        .mem_req_o(seq_req), .mem_addr_o(seq_addr), .mem_rvalid_i(seq_rvalid),
        .entry_i(mem_rdata), .itr_i_o, .itr_j_o, .itr_k_o
    );

    // one word per ready cycle
    stream_mac u_mac (
        .clk, .rst, .clear_i(load_done), .valid_i(ready_stream_o), .data_i(stream_data_i),
        .itr_i_i(itr_i_o), .itr_j_i(itr_j_o), .itr_k_i(itr_k_o), .acc_o(acc)
    );

endmodule

`default_nettype wire

// File: tests/tb_loop_model.svh
`ifndef tb_loop_model_svh
`define tb_loop_model_svh

// table image of the current test
logic [47:0] tbl_q[$];
// iterators {i, j, k} of every ready cycle of the walk, in order
logic [95:0] itq[$];

function automatic logic [47:0] make_entry(input logic        vld,
                                           input level_e      lvl,
                                           input entry_type_e typ,
                                           input logic [31:0] trig);
    return {vld, lvl, 5'd0, 5'd1, typ, 1'b0, trig};  // sc 0 of 1
endfunction

// cnt ready cycles that see the same iterators
function automatic void push_cycles(input int cnt, input int i, input int j, input int k);
    for (int c = 0; c < cnt; c++) begin
        itq.push_back({32'(i), 32'(j), 32'(k)});
    end
endfunction

function automatic void build_single(input int n);
    tbl_q.delete();
    itq.delete();
    tbl_q.push_back(make_entry(1'b1, lvl_k, init, 32'(n)));
    tbl_q.push_back(make_entry(1'b1, lvl_k, body_check_end, '0));
    tbl_q.push_back(make_entry(1'b0, lvl_k, init, '0));  // end of table
    push_cycles(2, 0, 0, 0);  // one entry covers an address and a data cycle
    for (int k = 0; k < n; k++) push_cycles(2, 0, 0, k);  // k check before its bump
    push_cycles(1, 0, 0, 0);  // end row, address cycle only
endfunction

function automatic void build_nest(input int bi, input int bj, input int bk);
    tbl_q.delete();
    itq.delete();
    tbl_q.push_back(make_entry(1'b1, lvl_i, init, 32'(bi)));
    tbl_q.push_back(make_entry(1'b1, lvl_j, init, 32'(bj)));  // i loop returns here
    tbl_q.push_back(make_entry(1'b1, lvl_k, init, 32'(bk)));  // j loop returns here
    tbl_q.push_back(make_entry(1'b1, lvl_k, body_check_end, '0));
    tbl_q.push_back(make_entry(1'b1, lvl_j, body_check_end, '0));
    tbl_q.push_back(make_entry(1'b1, lvl_i, body_check_end, '0));
    tbl_q.push_back(make_entry(1'b0, lvl_k, init, '0));
    push_cycles(2, 0, 0, 0);
    for (int i = 0; i < bi; i++) begin
        push_cycles(2, i, 0, 0);  // init j, j and k at zero
        for (int j = 0; j < bj; j++) begin
            push_cycles(2, i, j, 0);  // init k
            for (int k = 0; k < bk; k++) push_cycles(2, i, j, k);
            push_cycles(2, i, j, 0);  // j check, k cleared
        end
        push_cycles(2, i, 0, 0);  // i check
    end
    push_cycles(1, 0, 0, 0);  // iterators all back at zero
endfunction

// ready cycles of a walk, for the watchdog
function automatic int words_single(input int n);
    return 3 + 2 * n;
endfunction

function automatic int words_nest(input int bi, input int bj, input int bk);
    return 3 + bi * (4 + bj * (4 + 2 * bk));
endfunction

`endif

// File: tests/tb_loop_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_loop_top;
    import loop_pkg::*;

    logic        clk, rst;
    logic [7:0]  awaddr_i, araddr_i;
    logic        awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    logic [31:0] wdata_i;
    logic [3:0]  wstrb_i;
    logic        awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    logic [1:0]  bresp_o, rresp_o;
    logic [31:0] rdata_o;
    logic        start_stream_i, ready_stream_o;
    logic [31:0] stream_data_i, itr_i_o, itr_j_o, itr_k_o;
    logic [31:0] seed = 32'h41c9_002e;
    logic [63:0] exp_acc;         // model sum of the last walk
    int          wd_cycles = 0;   // watchdog armed once nonzero
    int          nk, bi, bj, bk;  // loop bounds

    `include "tb_loop_model.svh"

    loop_top #(.table_depth(32)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int bp);
        logic hs;
        @(negedge clk);
        awaddr_i  = addr;
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        do begin
            #1 hs = awready_o;  // mid low phase
            if (hs) check("wready with awready", 1, wready_o);
            @(negedge clk);
        end while (!hs);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        while (!bvalid_o) @(negedge clk);
        check("bresp okay", 0, bresp_o);
        repeat (bp) begin
            @(negedge clk);
            check("bvalid held", 1, bvalid_o);
        end
        bready_i = 1'b1;
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int bp, output logic [31:0] data);
        logic hs;
        @(negedge clk);
        araddr_i  = addr;
        arvalid_i = 1'b1;
        do begin
            #1 hs = arready_o;
            @(negedge clk);
        end while (!hs);
        arvalid_i = 1'b0;
        while (!rvalid_o) @(negedge clk);
        check("rresp okay", 0, rresp_o);
        data = rdata_o;
        repeat (bp) begin
            @(negedge clk);
            check("rvalid held", 1, rvalid_o);
            check("rdata held", data, rdata_o);
        end
        rready_i = 1'b1;
        @(negedge clk);
        rready_i = 1'b0;
    endtask

    task automatic load_table();
        foreach (tbl_q[r]) begin
            axi_write(reg_entry_lo, tbl_q[r][31:0], 0);
            axi_write(reg_entry_hi, 32'(tbl_q[r][47:32]), 0);  // commits row r
        end
    endtask

    // start pulse held for hold cycles, then one word per ready cycle
    task automatic run_stream(input string name, input int hold);
        int          n;
        int          w;
        logic [31:0] d;
        logic [95:0] t;  // model iterators i, j, k of this cycle
        n       = 0;
        exp_acc = '0;
        @(negedge clk);
        start_stream_i = 1'b1;
        @(negedge clk);
        check({name, " ready in hold"}, 1, ready_stream_o);
        while (ready_stream_o) begin
            t = (n >= hold && n - hold < itq.size()) ? itq[n - hold] : '0;  // zero while held
            check({name, " itr_i"}, t[95:64], itr_i_o);
            check({name, " itr_j"}, t[63:32], itr_j_o);
            check({name, " itr_k"}, t[31:0], itr_k_o);
            w = int'(t[95:64] + t[63:32] + t[31:0]) + 1;  // i+j+k+1
            d = lcg();
            stream_data_i = d;
            exp_acc += 64'(d) * 64'(w);
            n++;
            if (n == hold) start_stream_i = 1'b0;  // ready_hold ends next edge
            @(negedge clk);
        end
        check({name, " word count"}, hold + itq.size(), n);
    endtask

    task automatic check_result(input string name, input logic [63:0] acc_exp,
                                input logic done_exp);
        logic [31:0] lo, hi, st;
        axi_read(reg_acc_lo, 0, lo);
        axi_read(reg_acc_hi, 0, hi);
        axi_read(reg_status, 0, st);
        check({name, " acc"}, acc_exp, {hi, lo});
        check({name, " done"}, 64'(done_exp), 64'(st));
    endtask

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired before the test sequence finished");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] rd;
        rst            = 1'b1;
        awaddr_i       = '0;
        araddr_i       = '0;
        awvalid_i      = 1'b0;
        wvalid_i       = 1'b0;
        bready_i       = 1'b0;
        arvalid_i      = 1'b0;
        rready_i       = 1'b0;
        wdata_i        = '0;
        wstrb_i        = 4'hf;
        start_stream_i = 1'b0;
        stream_data_i  = '0;
        nk = 1 + int'(lcg() >> 30);  // bounds 1 to 4
        bi = 1 + int'(lcg() >> 30);
        bj = 1 + int'(lcg() >> 30);
        bk = 1 + int'(lcg() >> 30);
        wd_cycles = 200 * (words_single(nk) + 2 * words_nest(bi, bj, bk) + 12) + 2000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check("reset ready", 0, ready_stream_o);
        check_result("reset", '0, 1'b0);

        // single k loop
        build_single(nk);
        load_table();
        axi_write(reg_ctrl, '0, 0);
        repeat (3) begin
            @(negedge clk);
            check("ready before start", 0, ready_stream_o);
        end
        run_stream("single_k", 1 + int'(lcg() >> 30));
        check("single_k itr_k", 0, itr_k_o);
        check_result("single_k", exp_acc, 1'b1);

        // random i/j/k nest
        build_nest(bi, bj, bk);
        load_table();
        axi_write(reg_ctrl, '0, 0);
        run_stream("nest", 2);
        check_result("nest", exp_acc, 1'b1);

        // same table, no reload
        axi_write(reg_ctrl, '0, 0);
        check_result("rerun clear", '0, 1'b0);
        run_stream("rerun", 3);
        check_result("rerun", exp_acc, 1'b1);

        // responses stalled by bready and rready
        axi_write(reg_entry_lo, lcg(), 1 + int'(lcg() >> 29));
        axi_read(reg_acc_lo, 1 + int'(lcg() >> 29), rd);
        check("stalled acc_lo", exp_acc[31:0], rd);
        axi_read(reg_status, 1 + int'(lcg() >> 29), rd);
        check("stalled status", 1, rd);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+tests
source/loop_pkg.sv
source/loop_table_mem.sv
source/table_arbiter.sv
source/axil_regs.sv
source/loop_sequencer.sv
source/stream_mac.sv
source/loop_top.sv
tests/tb_loop_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator and looks for the pass line in the run output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_loop_top -o tb_loop_top &&
./obj_dir/tb_loop_top | tee /dev/stderr | grep -qF '*** PASSED ***' ||
{ echo "simulation failed"; exit 1; }
